/* Makefile */
# Verilator build of the issue back end testbench

VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* dv/backend_props.sv */
`timescale 1ns/100ps

module backend_props import ooo_pkg::*; (
    input logic  clk,
    input logic  reset_i,
    input logic  flush_i,
    input logic  disp_ready_i,
    input logic  cdb_valid_i,
    input preg_t cdb_tag_i
);

    // reset or flush empties every fifo, nothing left to broadcast
    a_cdb_quiet: assert property (@(posedge clk) (reset_i || flush_i) |=> !cdb_valid_i)
        else $error("cdb_valid_o high in the cycle after reset or flush");

    a_cdb_tag_known: assert property (
        @(posedge clk) disable iff (reset_i) cdb_valid_i |-> !$isunknown(cdb_tag_i)
    ) else $error("cdb_tag_o unknown while cdb_valid_o is high");

    // queues empty after flush, any target has room
    a_ready_after_flush: assert property (@(posedge clk) flush_i |=> disp_ready_i)
        else $error("disp_ready_o low in the cycle after flush");

endmodule

bind issue_backend_top backend_props i_props (
    .clk         (clk),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .disp_ready_i(disp_ready_o),
    .cdb_valid_i (cdb_valid_o),
    .cdb_tag_i   (cdb_tag_o)
);

/* dv/backend_tb.sv */
`timescale 1ns/100ps

module backend_tb import ooo_pkg::*; ();

    localparam int IQ_DEPTH       = 4;
    localparam int RES_FIFO_DEPTH = 2;
    localparam int STREAM_LEN     = 40;     // contention test length
    // dispatch count summed over every test in run order
    localparam int NUM_DISP        = 2 * 8 + 2 + (IQ_DEPTH + 1) + (2 * IQ_DEPTH + STREAM_LEN) + 5;
    localparam int WATCHDOG_CYCLES = NUM_DISP * 20;

    logic    clk;
    logic    reset_i;
    logic    flush_i;
    logic    disp_valid_i;
    iq_idx_t disp_iq_i;
    alu_op_t disp_op_i;
    preg_t   disp_dst_i;
    preg_t   disp_src1_tag_i;
    logic    disp_src1_rdy_i;
    word_t   disp_src1_data_i;
    preg_t   disp_src2_tag_i;
    logic    disp_src2_rdy_i;
    word_t   disp_src2_data_i;
    logic    disp_ready_o;
    logic    cdb_valid_o;
    preg_t   cdb_tag_o;
    word_t   cdb_data_o;

    word_t exp_data  [preg_t];  // tag -> reference result
    word_t seen_data [preg_t];  // tag -> value seen on the cdb

    issue_backend_top #(.IQ_DEPTH(IQ_DEPTH), .RES_FIFO_DEPTH(RES_FIFO_DEPTH)) UUT (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .disp_valid_i    (disp_valid_i),
        .disp_iq_i       (disp_iq_i),
        .disp_op_i       (disp_op_i),
        .disp_dst_i      (disp_dst_i),
        .disp_src1_tag_i (disp_src1_tag_i),
        .disp_src1_rdy_i (disp_src1_rdy_i),
        .disp_src1_data_i(disp_src1_data_i),
        .disp_src2_tag_i (disp_src2_tag_i),
        .disp_src2_rdy_i (disp_src2_rdy_i),
        .disp_src2_data_i(disp_src2_data_i),
        .disp_ready_o    (disp_ready_o),
        .cdb_valid_o     (cdb_valid_o),
        .cdb_tag_o       (cdb_tag_o),
        .cdb_data_o      (cdb_data_o)
    );

    always #10 clk = ~clk;  // 20 ns period

    task automatic abort_run(input string why);
        $display("** FAIL **");
        $fatal(1, "%s", why);
    endtask

    task automatic check_equal(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s, got %h expected %h", $time, what, got, expected);
            abort_run("value mismatch");
        end
    endtask

    // reference alu built from the operation rules
    function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t b);
        int unsigned sh;
        sh = b % 32;    // shift amount from the low 5 bits
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 32'd1;   // two's complement subtract
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return (int'(a) < int'(b)) ? 32'd1 : 32'd0;
            OP_SLL:  return a << sh;
            default: return a >> sh;          // srl
        endcase
    endfunction

    // cdb is stable mid cycle so each broadcast is recorded here once
    always @(negedge clk) begin
        if (!reset_i && cdb_valid_o === 1'b1) begin
            if (!exp_data.exists(cdb_tag_o)) begin
                abort_run($sformatf("tag %0d broadcast but not expected", cdb_tag_o));
            end else if (seen_data.exists(cdb_tag_o)) begin
                abort_run($sformatf("tag %0d broadcast twice", cdb_tag_o));
            end else begin
                seen_data[cdb_tag_o] = cdb_data_o;
            end
        end
    end

    // called just after a falling edge and returns just after one
    task automatic send_instr(input iq_idx_t iq, input alu_op_t op, input preg_t dst,
                              input preg_t t1, input logic r1, input word_t d1,
                              input preg_t t2, input logic r2, input word_t d2);
        logic taken;
        disp_iq_i        = iq;
        disp_op_i        = op;
        disp_dst_i       = dst;
        disp_src1_tag_i  = t1;
        disp_src1_rdy_i  = r1;
        disp_src1_data_i = d1;
        disp_src2_tag_i  = t2;
        disp_src2_rdy_i  = r2;
        disp_src2_data_i = d2;
        disp_valid_i     = 1'b1;
        taken            = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = disp_ready_o;   // pre-edge value that the queue acts on
            @(negedge clk);
        end
        disp_valid_i = 1'b0;
    endtask

    task automatic send_ready(input iq_idx_t iq, input alu_op_t op, input preg_t dst,
                              input word_t a, input word_t b);
        exp_data[dst] = model_alu(op, a, b);
        send_instr(iq, op, dst, '0, 1'b1, a, '0, 1'b1, b);
    endtask

    // src1 waits on wait_tag and the caller books the expected value
    task automatic send_waiting(input iq_idx_t iq, input alu_op_t op, input preg_t dst,
                                input preg_t wait_tag, input word_t b);
        send_instr(iq, op, dst, wait_tag, 1'b0, $urandom(), '0, 1'b1, b);
    endtask

    task automatic sample_ready(input iq_idx_t iq, output logic rdy);
        disp_iq_i = iq;
        @(posedge clk);
        rdy = disp_ready_o;
        @(negedge clk);
    endtask

    task automatic wait_all_broadcast();
        while (seen_data.num() != exp_data.num()) @(negedge clk);
        repeat (4) @(negedge clk);  // a late duplicate trips the monitor
        foreach (exp_data[t]) check_equal($sformatf("tag %0d", t), seen_data[t], exp_data[t]);
        exp_data.delete();
        seen_data.delete();
    endtask

    task automatic test_all_ops();
        for (int q = 0; q < NUM_ALU_IQ; q++) begin
            for (int op = 0; op < 8; op++) begin
                send_ready(iq_idx_t'(q), alu_op_t'(op), preg_t'(q * 8 + op), $urandom(), $urandom());
            end
        end
        wait_all_broadcast();
    endtask

    task automatic test_wakeup();
        word_t a, b, c;
        a = $urandom();
        b = $urandom();
        c = $urandom();
        // consumer first, producer of tag 20 only afterward on the other queue
        exp_data[6'd21] = model_alu(OP_SUB, model_alu(OP_XOR, a, b), c);
        send_waiting(1'b0, OP_SUB, 6'd21, 6'd20, c);
        send_ready(1'b1, OP_XOR, 6'd20, a, b);
        wait_all_broadcast();
    endtask

    task automatic test_queue_full();
        word_t a, b, v;
        logic  rdy;
        a = $urandom();
        b = $urandom();
        for (int i = 0; i < IQ_DEPTH; i++) begin
            v = $urandom();
            exp_data[preg_t'(40 + i)] = model_alu(alu_op_t'(i % 8), model_alu(OP_ADD, a, b), v);
            send_waiting(1'b0, alu_op_t'(i % 8), preg_t'(40 + i), 6'd39, v);
        end
        sample_ready(1'b0, rdy);
        check_equal("queue 0 ready while full", word_t'(rdy), 32'd0);
        send_ready(1'b1, OP_ADD, 6'd39, a, b);  // wakes all of queue 0
        wait_all_broadcast();
        sample_ready(1'b0, rdy);
        check_equal("queue 0 ready after drain", word_t'(rdy), 32'd1);
    endtask

    task automatic test_contention();
        iq_idx_t q;
        alu_op_t op;
        word_t   a, b, v;
        a = $urandom();
        b = $urandom();
        // both queues wake on tag 60 in one cycle and fight for the cdb
        for (int i = 0; i < 2 * IQ_DEPTH - 1; i++) begin
            v  = $urandom();
            op = alu_op_t'($urandom() % 8);
            exp_data[preg_t'(41 + i)] = model_alu(op, model_alu(OP_AND, a, b), v);
            send_waiting(iq_idx_t'(i % 2), op, preg_t'(41 + i), 6'd60, v);
        end
        send_ready(1'b1, OP_AND, 6'd60, a, b);  // last free slot, queue 1
        for (int i = 0; i < STREAM_LEN; i++) begin
            q  = iq_idx_t'($urandom() % 2);
            op = alu_op_t'($urandom() % 8);
            send_ready(q, op, preg_t'(i + 1), $urandom(), $urandom());
        end
        wait_all_broadcast();
    endtask

    task automatic test_flush();
        word_t a, b, v;
        logic  rdy;
        // tag 50 has no producer yet and none of these are booked
        send_waiting(1'b0, OP_ADD, 6'd51, 6'd50, $urandom());
        send_waiting(1'b0, OP_OR, 6'd52, 6'd50, $urandom());
        send_waiting(1'b1, OP_SLL, 6'd53, 6'd50, $urandom());
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        sample_ready(1'b0, rdy);
        check_equal("queue 0 ready after flush", word_t'(rdy), 32'd1);
        a = $urandom();
        b = $urandom();
        v = $urandom();
        // producing tag 50 now must not revive 51..53
        exp_data[6'd54] = model_alu(OP_XOR, model_alu(OP_SUB, a, b), v);
        send_waiting(1'b1, OP_XOR, 6'd54, 6'd50, v);
        send_ready(1'b0, OP_SUB, 6'd50, a, b);
        wait_all_broadcast();
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired, tests not done after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'h857acb68));  // single seed for the run
        clk              = 1'b0;
        reset_i          = 1'b1;
        flush_i          = 1'b0;
        disp_valid_i     = 1'b0;
        disp_iq_i        = 1'b0;
        disp_op_i        = OP_ADD;
        disp_dst_i       = '0;
        disp_src1_tag_i  = '0;
        disp_src1_rdy_i  = 1'b0;
        disp_src1_data_i = '0;
        disp_src2_tag_i  = '0;
        disp_src2_rdy_i  = 1'b0;
        disp_src2_data_i = '0;
        repeat (2) @(negedge clk);      // two rising edges in reset
        reset_i = 1'b0;
        test_all_ops();
        test_wakeup();
        test_queue_full();
        test_contention();
        test_flush();
        $display("** PASS **");
        $finish;
    end

endmodule

/* sources.f */
verilog/ooo_pkg.sv
verilog/dispatch_if.sv
verilog/fu_result_if.sv
verilog/alu.sv
verilog/alu_iq.sv
verilog/result_fifo.sv
verilog/cdb_arbiter.sv
verilog/issue_backend_top.sv
dv/backend_props.sv
dv/backend_tb.sv

/* verilog/alu.sv */
`timescale 1ns/100ps

// single cycle integer alu, pure comb
module alu import ooo_pkg::*; (
    input  alu_op_t op_i,
    input  word_t   src1_i,
    input  word_t   src2_i,
    output word_t   result_o
);

    always_comb begin
        result_o = '0;
        case (op_i)
            OP_ADD: result_o = src1_i + src2_i;
            OP_SUB: result_o = src1_i - src2_i;
            OP_AND: result_o = src1_i & src2_i;
            OP_OR:  result_o = src1_i | src2_i;
            OP_XOR: result_o = src1_i ^ src2_i;
            OP_SLT: begin
                // signed less-than, zero extended to a word
                result_o = {{(WORD_W-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
            end
            OP_SLL: result_o = src1_i << src2_i[4:0];   // only low 5 bits count
            OP_SRL: result_o = src1_i >> src2_i[4:0];   // logical, no sign fill
            default: result_o = '0;
        endcase
    end

endmodule

/* verilog/alu_iq.sv */
`timescale 1ns/100ps

module alu_iq import ooo_pkg::*; #(
    parameter int IQ_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      flush_i,
    dispatch_if.queue disp,
    input  logic      fifo_full_i,      // result fifo cannot take an issue
    input  logic      cdb_valid_i,
    input  preg_t     cdb_tag_i,
    input  word_t     cdb_data_i,
    output logic      issue_valid_o,    // push strobe into result fifo
    output preg_t     issue_tag_o,
    output word_t     issue_data_o
);

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0] ent_valid;     // only control state in the queue
    alu_op_t             ent_op      [IQ_DEPTH];
    preg_t               ent_dst     [IQ_DEPTH];
    preg_t               ent_s1_tag  [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] ent_s1_rdy;
    word_t               ent_s1_data [IQ_DEPTH];
    preg_t               ent_s2_tag  [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] ent_s2_rdy;
    word_t               ent_s2_data [IQ_DEPTH];

    logic [IQ_DEPTH-1:0] wake1;         // cdb hits a waiting src1
    logic [IQ_DEPTH-1:0] wake2;
    logic [IQ_DEPTH-1:0] ent_ready;     // both operands present

    logic             free_found;
    logic [IDX_W-1:0] alloc_idx;
    logic             alloc_en;
    logic             sel_found;
    logic [IDX_W-1:0] sel_idx;
    logic             issue_fire;

    // operands as written at dispatch, cdb forwarded if it matches now
    logic  d_s1_rdy;
    logic  d_s2_rdy;
    word_t d_s1_data;
    word_t d_s2_data;

    assign d_s1_rdy  = disp.src1_rdy || (cdb_valid_i && cdb_tag_i == disp.src1_tag);
    assign d_s2_rdy  = disp.src2_rdy || (cdb_valid_i && cdb_tag_i == disp.src2_tag);
    assign d_s1_data = disp.src1_rdy ? disp.src1_data : cdb_data_i;
    assign d_s2_data = disp.src2_rdy ? disp.src2_data : cdb_data_i;

    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            wake1[i]     = cdb_valid_i && !ent_s1_rdy[i] && (ent_s1_tag[i] == cdb_tag_i);
            wake2[i]     = cdb_valid_i && !ent_s2_rdy[i] && (ent_s2_tag[i] == cdb_tag_i);
            ent_ready[i] = ent_valid[i] && ent_s1_rdy[i] && ent_s2_rdy[i];
        end
    end

    // lowest free slot, walk down so the lowest index lands last
    always_comb begin
        free_found = 1'b0;
        alloc_idx  = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_found = 1'b1;
                alloc_idx  = IDX_W'(i);
            end
        end
    end

    // lowest ready entry wins issue
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (ent_ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    assign disp.ready = free_found;
    assign alloc_en   = disp.valid && free_found;
    assign issue_fire = sel_found && !fifo_full_i;    // full fifo holds the entry

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ent_valid <= '0;
        end else begin
            if (issue_fire) ent_valid[sel_idx] <= 1'b0;   // freed as it leaves
            if (alloc_en) ent_valid[alloc_idx] <= 1'b1;   // never the issuing slot
        end
    end

    // payload, written on allocate, operands patched by cdb snoop
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (alloc_en && alloc_idx == IDX_W'(i)) begin
                ent_op[i]      <= disp.op;
                ent_dst[i]     <= disp.dst;
                ent_s1_tag[i]  <= disp.src1_tag;
                ent_s1_rdy[i]  <= d_s1_rdy;
                ent_s1_data[i] <= d_s1_data;
                ent_s2_tag[i]  <= disp.src2_tag;
                ent_s2_rdy[i]  <= d_s2_rdy;
                ent_s2_data[i] <= d_s2_data;
            end else begin
                if (wake1[i]) begin
                    ent_s1_rdy[i]  <= 1'b1;
                    ent_s1_data[i] <= cdb_data_i;
                end
                if (wake2[i]) begin
                    ent_s2_rdy[i]  <= 1'b1;
                    ent_s2_data[i] <= cdb_data_i;
                end
            end
        end
    end

    alu i_alu (
        .op_i    (ent_op[sel_idx]),
        .src1_i  (ent_s1_data[sel_idx]),
        .src2_i  (ent_s2_data[sel_idx]),
        .result_o(issue_data_o)
    );

    assign issue_valid_o = issue_fire;
    assign issue_tag_o   = ent_dst[sel_idx];

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/100ps

module cdb_arbiter import ooo_pkg::*; (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    fu_result_if.sink res [NUM_ALU_IQ],
    output logic     cdb_valid_o,
    output preg_t    cdb_tag_o,
    output word_t    cdb_data_o
);

    localparam int SRC_W = (NUM_ALU_IQ > 1) ? $clog2(NUM_ALU_IQ) : 1;

    logic [NUM_ALU_IQ-1:0] src_valid;
    preg_t                 src_tag  [NUM_ALU_IQ];
    word_t                 src_data [NUM_ALU_IQ];
    logic [SRC_W-1:0]      rr_ptr;      // highest priority source this cycle
    logic                  gnt_found;
    logic [SRC_W-1:0]      gnt_idx;

    for (genvar g = 0; g < NUM_ALU_IQ; g++) begin : g_src
        assign src_valid[g] = res[g].valid;
        assign src_tag[g]   = res[g].tag;
        assign src_data[g]  = res[g].data;
        assign res[g].ready = gnt_found && (gnt_idx == SRC_W'(g));  // pop granted head only
    end

    // first valid source at or after rr_ptr
    always_comb begin : grant_sel
        int cand;
        gnt_found = 1'b0;
        gnt_idx   = '0;
        for (int k = NUM_ALU_IQ - 1; k >= 0; k--) begin
            cand = (int'(rr_ptr) + k) % NUM_ALU_IQ;
            if (src_valid[cand]) begin
                gnt_found = 1'b1;
                gnt_idx   = SRC_W'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            rr_ptr <= '0;
        end else if (gnt_found) begin
            // winner drops to lowest priority
            rr_ptr <= (gnt_idx == SRC_W'(NUM_ALU_IQ - 1)) ? '0 : gnt_idx + 1'b1;
        end
    end

    assign cdb_valid_o = gnt_found;     // plain strobe, nobody can stall it
    assign cdb_tag_o   = src_tag[gnt_idx];
    assign cdb_data_o  = src_data[gnt_idx];

endmodule

/* verilog/dispatch_if.sv */
`timescale 1ns/100ps

// one dispatched instruction, top level -> alu issue queue
interface dispatch_if import ooo_pkg::*; ();

    logic    valid;       // instruction present
    logic    ready;       // queue has a free entry
    alu_op_t op;
    preg_t   dst;         // result tag
    preg_t   src1_tag;
    logic    src1_rdy;    // src1_data already valid
    word_t   src1_data;
    preg_t   src2_tag;
    logic    src2_rdy;
    word_t   src2_data;

    modport source (
        output valid, op, dst, src1_tag, src1_rdy, src1_data, src2_tag, src2_rdy, src2_data,
        input  ready
    );

    modport queue (
        input  valid, op, dst, src1_tag, src1_rdy, src1_data, src2_tag, src2_rdy, src2_data,
        output ready
    );

endinterface

/* verilog/fu_result_if.sv */
`timescale 1ns/100ps

// executed result waiting for the cdb
interface fu_result_if import ooo_pkg::*; ();

    logic  valid;   // fifo not empty
    logic  ready;   // granted by the arbiter, pops head
    preg_t tag;
    word_t data;

    modport source (
        output valid, tag, data,
        input  ready
    );

    modport sink (
        input  valid, tag, data,
        output ready
    );

endinterface

/* verilog/issue_backend_top.sv */
`timescale 1ns/100ps

module issue_backend_top import ooo_pkg::*; #(
    parameter int IQ_DEPTH       = 4,
    parameter int RES_FIFO_DEPTH = 2
) (
    input  logic    clk,
    input  logic    reset_i,
    input  logic    flush_i,
    input  logic    disp_valid_i,
    input  iq_idx_t disp_iq_i,          // target alu queue
    input  alu_op_t disp_op_i,
    input  preg_t   disp_dst_i,
    input  preg_t   disp_src1_tag_i,
    input  logic    disp_src1_rdy_i,
    input  word_t   disp_src1_data_i,
    input  preg_t   disp_src2_tag_i,
    input  logic    disp_src2_rdy_i,
    input  word_t   disp_src2_data_i,
    output logic    disp_ready_o,
    output logic    cdb_valid_o,
    output preg_t   cdb_tag_o,
    output word_t   cdb_data_o
);

    logic [NUM_ALU_IQ-1:0] iq_ready;
    logic [NUM_ALU_IQ-1:0] issue_valid;
    preg_t                 issue_tag  [NUM_ALU_IQ];
    word_t                 issue_data [NUM_ALU_IQ];
    logic [NUM_ALU_IQ-1:0] fifo_full;

    // single cdb lane, also the wakeup bus
    logic  cdb_valid;
    preg_t cdb_tag;
    word_t cdb_data;

    dispatch_if  disp_if [NUM_ALU_IQ] ();
    fu_result_if res_if  [NUM_ALU_IQ] ();

    for (genvar g = 0; g < NUM_ALU_IQ; g++) begin : g_alu
        // valid goes to one queue, payload fans out to all
        assign disp_if[g].valid     = disp_valid_i && (disp_iq_i == iq_idx_t'(g));
        assign disp_if[g].op        = disp_op_i;
        assign disp_if[g].dst       = disp_dst_i;
        assign disp_if[g].src1_tag  = disp_src1_tag_i;
        assign disp_if[g].src1_rdy  = disp_src1_rdy_i;
        assign disp_if[g].src1_data = disp_src1_data_i;
        assign disp_if[g].src2_tag  = disp_src2_tag_i;
        assign disp_if[g].src2_rdy  = disp_src2_rdy_i;
        assign disp_if[g].src2_data = disp_src2_data_i;
        assign iq_ready[g]          = disp_if[g].ready;

        alu_iq #(.IQ_DEPTH(IQ_DEPTH)) i_alu_iq (
            .clk          (clk),
            .reset_i      (reset_i),
            .flush_i      (flush_i),
            .disp         (disp_if[g]),
            .fifo_full_i  (fifo_full[g]),
            .cdb_valid_i  (cdb_valid),
            .cdb_tag_i    (cdb_tag),
            .cdb_data_i   (cdb_data),
            .issue_valid_o(issue_valid[g]),
            .issue_tag_o  (issue_tag[g]),
            .issue_data_o (issue_data[g])
        );

        result_fifo #(.RES_FIFO_DEPTH(RES_FIFO_DEPTH)) i_res_fifo (
            .clk        (clk),
            .reset_i    (reset_i),
            .flush_i    (flush_i),
            .push_i     (issue_valid[g]),
            .push_tag_i (issue_tag[g]),
            .push_data_i(issue_data[g]),
            .full_o     (fifo_full[g]),
            .res        (res_if[g])
        );
    end

    assign disp_ready_o = iq_ready[disp_iq_i];    // same cycle, selected queue only

    cdb_arbiter i_cdb_arb (
        .clk        (clk),
        .reset_i    (reset_i),
        .flush_i    (flush_i),
        .res        (res_if),
        .cdb_valid_o(cdb_valid),
        .cdb_tag_o  (cdb_tag),
        .cdb_data_o (cdb_data)
    );

    assign cdb_valid_o = cdb_valid;
    assign cdb_tag_o   = cdb_tag;
    assign cdb_data_o  = cdb_data;

endmodule

/* verilog/ooo_pkg.sv */
package ooo_pkg;

    // base widths
    localparam int WORD_W = 32;     // integer datapath
    localparam int PREG_W = 6;      // physical register tag
    localparam int OP_W   = 3;      // alu operation code

    // operand / result value
    typedef logic [WORD_W-1:0] word_t;

    // producer tag, also the cdb wakeup key
    typedef logic [PREG_W-1:0] preg_t;

    // alu operation code
    typedef logic [OP_W-1:0] alu_op_t;

    // which alu issue queue takes the dispatch
    typedef logic iq_idx_t;

    // operation codes
    localparam alu_op_t OP_ADD = 3'd0;  // src1 + src2
    localparam alu_op_t OP_SUB = 3'd1;  // src1 - src2
    localparam alu_op_t OP_AND = 3'd2;
    localparam alu_op_t OP_OR  = 3'd3;
    localparam alu_op_t OP_XOR = 3'd4;
    localparam alu_op_t OP_SLT = 3'd5;  // signed compare, 1 or 0
    localparam alu_op_t OP_SLL = 3'd6;  // shift amount from src2[4:0]
    localparam alu_op_t OP_SRL = 3'd7;  // logical, zero fill

    // alu queues, one result fifo each, all feeding one cdb lane
    localparam int NUM_ALU_IQ = 2;

endpackage

/* verilog/result_fifo.sv */
`timescale 1ns/100ps

module result_fifo import ooo_pkg::*; #(
    parameter int RES_FIFO_DEPTH = 2
) (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          push_i,       // issue strobe from the queue
    input  preg_t         push_tag_i,
    input  word_t         push_data_i,
    output logic          full_o,
    fu_result_if.source   res
);

    localparam int PTR_W = (RES_FIFO_DEPTH > 1) ? $clog2(RES_FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(RES_FIFO_DEPTH + 1);

    preg_t            tag_mem  [RES_FIFO_DEPTH];
    word_t            data_mem [RES_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(RES_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o  = (count == CNT_W'(RES_FIFO_DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = res.valid && res.ready;  // arbiter grant

    // head straight from storage, no write bypass
    assign res.valid = (count != '0);
    assign res.tag   = tag_mem[rd_ptr];
    assign res.data  = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_next(wr_ptr);
            if (do_pop) rd_ptr <= ptr_next(rd_ptr);
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            tag_mem[wr_ptr]  <= push_tag_i;
            data_mem[wr_ptr] <= push_data_i;
        end
    end

endmodule
